// File: common/ethTxPkg.sv
package ethTxPkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // one data byte on the bus, in the buffer and on the line
  typedef logic [7:0] byteT;

  // frame buffer address, 512 entries
  typedef logic [8:0] bufAddrT;

  // wishbone byte address: buffer below 0x200, registers above
  typedef logic [9:0] wbAddrT;

  // frame byte count, 1 to 512
  typedef logic [9:0] frameLenT;

  // crc shift register
  typedef logic [31:0] crcT;

  //////////////////////////////
  // address map and constants
  //////////////////////////////

  localparam int BufDepth = 512;

  // length low byte, length upper bits, control/status
  localparam wbAddrT RegLength   = 10'h200;
  localparam wbAddrT RegLengthHi = 10'h201;
  localparam wbAddrT RegControl  = 10'h202;

  localparam byteT PreambleByte = 8'h55;
  localparam byteT SfdByte      = 8'hD5;

  // preamble bytes including the sfd
  localparam frameLenT PreambleBytes = 10'd8;
  // fcs length in bytes
  localparam frameLenT FcsBytes      = 10'd4;

  localparam crcT CrcPoly = 32'h04C11DB7;
  localparam crcT CrcInit = 32'hFFFFFFFF;

  // tp_idl: line held high after the last bit
  localparam logic [2:0] IdleHighCycles = 3'd6;

  // normal link pulse spacing in clocks (about 6.5 ms at 20 MHz)
  localparam int unsigned LinkPulsePeriod = 1 << 17;

  //////////////////////////////
  // structs and states
  //////////////////////////////

  // decoder to sequencer, start is a one-cycle pulse
  typedef struct packed {
    logic     start;
    frameLenT length;
  } txCmdT;

  // one manchester half-bit slot, sequencer to encoder
  typedef struct packed {
    logic active;
    logic dataBit;
    logic secondHalf;
  } lineSlotT;

  typedef enum logic [1:0] {
    sIdle,
    sPreamble,
    sPayload,
    sFcs
  } seqStateT;

endpackage

// File: hw/busDecode.sv
`timescale 1ns/100ps

module busDecode import ethTxPkg::*; (
  input  logic    clkTx,
  input  logic    rst,
  input  logic    wbCyc,
  input  logic    wbStb,
  input  logic    wbWe,
  input  wbAddrT  wbAdr,
  input  byteT    wbDatW,
  input  logic    busy,
  output byteT    wbDatR,
  output logic    wbAck,
  output logic    bufWrEn,
  output bufAddrT bufWrAddr,
  output byteT    bufWrData,
  output txCmdT   txCmd
);

  //////////////////////////////
  // request decode
  //////////////////////////////

  // new request, seen once since ack drops it out the cycle after
  logic access;
  logic wrAccess;
  logic bufSel;
  logic ctrlSel;

  assign access   = wbCyc & wbStb & ~wbAck;
  assign wrAccess = access & wbWe;

  // bit 9 clear selects the frame buffer
  assign bufSel  = ~wbAdr[9];
  assign ctrlSel = (wbAdr == RegControl);

  //////////////////////////////
  // single-cycle ack
  //////////////////////////////

  always_ff @(posedge clkTx)
  begin
    if (rst)
    begin
      wbAck <= 1'b0;
    end
    else
    begin
      wbAck <= access;
    end
  end

  // read data lines up with ack
  // only the status register returns anything
  always_ff @(posedge clkTx)
  begin
    if (access)
    begin
      wbDatR <= ctrlSel ? {7'b0, busy} : '0;
    end
  end

  //////////////////////////////
  // buffer writes
  //////////////////////////////

  // buffer is frozen while a frame is on the line
  assign bufWrEn   = wrAccess & bufSel & ~busy;
  assign bufWrAddr = wbAdr[8:0];
  assign bufWrData = wbDatW;

  //////////////////////////////
  // length and start
  //////////////////////////////

  always_ff @(posedge clkTx)
  begin
    if (rst)
    begin
      txCmd.start  <= 1'b0;
      txCmd.length <= '0;
    end
    else
    begin
      // start pulse, dropped while busy
      txCmd.start <= wrAccess & ctrlSel & wbDatW[0] & ~busy;

      if (wrAccess && wbAdr == RegLength)
      begin
        txCmd.length[7:0] <= wbDatW;
      end
      // upper bits, enough for lengths up to 512
      if (wrAccess && wbAdr == RegLengthHi)
      begin
        txCmd.length[9:8] <= wbDatW[1:0];
      end
    end
  end

endmodule

// File: hw/frameRam.sv
`timescale 1ns/100ps

module frameRam import ethTxPkg::*; (
  input  logic    clkTx,
  input  logic    bufWrEn,
  input  bufAddrT bufWrAddr,
  input  byteT    bufWrData,
  input  bufAddrT bufRdAddr,
  output byteT    bufRdData
);

  // frame bytes, host writes, sequencer reads
  byteT mem [BufDepth];

  // write port
  always_ff @(posedge clkTx)
  begin
    if (bufWrEn)
    begin
      mem[bufWrAddr] <= bufWrData;
    end
  end

  // registered read so it maps onto a block ram
  always_ff @(posedge clkTx)
  begin
    bufRdData <= mem[bufRdAddr];
  end

endmodule

// File: txFrame/crc32Serial.sv
`timescale 1ns/100ps

module crc32Serial import ethTxPkg::*; (
  input  logic clkTx,
  input  logic crcInit,
  input  logic crcShift,
  input  logic crcBit,
  input  logic crcOut,
  output logic crcMsb
);

  crcT crcReg;
  // feedback term for one data bit
  logic feedback;

  assign feedback = crcBit ^ crcReg[31];

  // data enters lsb first into an msb-first register,
  // the same result as the reflected ethernet crc
  always_ff @(posedge clkTx)
  begin
    if (crcInit)
    begin
      crcReg <= CrcInit;
    end
    else if (crcShift)
    begin
      crcReg <= {crcReg[30:0], 1'b0} ^ ({32{feedback}} & CrcPoly);
    end
    else if (crcOut)
    begin
      // flush: shift zeros, msb walks out one bit at a time
      crcReg <= {crcReg[30:0], 1'b0};
    end
  end

  assign crcMsb = crcReg[31];

endmodule

// File: txFrame/frameSequencer.sv
`timescale 1ns/100ps

module frameSequencer import ethTxPkg::*; (
  input  logic     clkTx,
  input  logic     rst,
  input  txCmdT    txCmd,
  input  byteT     bufRdData,
  output logic     busy,
  output bufAddrT  bufRdAddr,
  output lineSlotT slot
);

  seqStateT state;
  seqStateT nextState;
  // half-bit slot inside the current byte, 16 per byte
  logic [3:0] halfCnt;
  // byte index inside the current field
  frameLenT byteCnt;
  frameLenT frameLen;
  byteT     shiftReg;
  byteT     nextByte;
  logic     byteEnd;
  logic     lastByte;
  logic     loadFromBuf;

  // crc unit handshake
  logic crcInit;
  logic crcShift;
  logic crcBit;
  logic crcOut;
  logic crcMsb;

  assign busy    = (state != sIdle);
  assign byteEnd = &halfCnt;

  //////////////////////////////
  // field sequencing
  //////////////////////////////

  always_comb
  begin
    lastByte  = 1'b0;
    nextState = state;
    case (state)
      sPreamble:
      begin
        lastByte  = (byteCnt == PreambleBytes - 1'b1);
        nextState = sPayload;
      end
      sPayload:
      begin
        lastByte  = (byteCnt == frameLen - 1'b1);
        nextState = sFcs;
      end
      sFcs:
      begin
        lastByte  = (byteCnt == FcsBytes - 1'b1);
        nextState = sIdle;
      end
      default:
      begin
        lastByte  = 1'b0;
        nextState = sIdle;
      end
    endcase
  end

  always_ff @(posedge clkTx)
  begin
    if (rst)
    begin
      state   <= sIdle;
      halfCnt <= '0;
      byteCnt <= '0;
    end
    else if (state == sIdle)
    begin
      if (txCmd.start)
      begin
        state   <= sPreamble;
        halfCnt <= '0;
        byteCnt <= '0;
      end
    end
    else
    begin
      halfCnt <= halfCnt + 1'b1;
      if (byteEnd)
      begin
        if (lastByte)
        begin
          // last fcs half-bit goes out here, busy drops next cycle
          state   <= nextState;
          byteCnt <= '0;
        end
        else
        begin
          byteCnt <= byteCnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // byte source and shifter
  //////////////////////////////

  // buffer fetch for the byte after the sfd and every payload byte but the last
  assign loadFromBuf = ((state == sPreamble) & lastByte) |
                       ((state == sPayload) & ~lastByte);

  always_comb
  begin
    if (loadFromBuf)
      nextByte = bufRdData;
    else if (state == sPreamble && byteCnt == PreambleBytes - 2'd2)
      nextByte = SfdByte;
    else
      nextByte = PreambleByte;
  end

  always_ff @(posedge clkTx)
  begin
    if (state == sIdle)
    begin
      shiftReg  <= PreambleByte;
      bufRdAddr <= '0;
      if (txCmd.start)
      begin
        frameLen <= txCmd.length;
      end
    end
    else if (byteEnd)
    begin
      shiftReg <= nextByte;
      // move the ram address on, data is ready long before the next byte end
      if (loadFromBuf)
      begin
        bufRdAddr <= bufRdAddr + 1'b1;
      end
    end
    else if (halfCnt[0])
    begin
      // lsb first, next bit after each full bit
      shiftReg <= {1'b0, shiftReg[7:1]};
    end
  end

  //////////////////////////////
  // crc and line slot
  //////////////////////////////

  // preset during the sfd byte
  assign crcInit  = (state == sPreamble) & (byteCnt == PreambleBytes - 1'b1);
  assign crcShift = (state == sPayload) & halfCnt[0];
  assign crcBit   = shiftReg[0];
  assign crcOut   = (state == sFcs) & halfCnt[0];

  crc32Serial i_crc32Serial (
    .clkTx    (clkTx),
    .crcInit  (crcInit),
    .crcShift (crcShift),
    .crcBit   (crcBit),
    .crcOut   (crcOut),
    .crcMsb   (crcMsb)
  );

  // fcs streams the inverted crc msb
  assign slot.active     = busy;
  assign slot.dataBit    = (state == sFcs) ? ~crcMsb : shiftReg[0];
  assign slot.secondHalf = halfCnt[0];

endmodule

// File: lineCoder/lineEncoder.sv
`timescale 1ns/100ps

module lineEncoder import ethTxPkg::*; (
  input  logic     clkTx,
  input  logic     rst,
  input  lineSlotT slot,
  output logic     tdP,
  output logic     tdM
);

  // clocks since the last active slot, saturates at IdleHighCycles
  logic [2:0] idleCnt;
  // idle time counter for normal link pulses
  logic [$clog2(LinkPulsePeriod)-1:0] linkCnt;
  logic linkPulse;
  logic tpIdle;
  // manchester level for the current half-bit
  logic manchester;

  //////////////////////////////
  // line state
  //////////////////////////////

  // 1 is low then high, 0 is high then low
  assign manchester = ~(slot.dataBit ^ slot.secondHalf);

  assign tpIdle    = (idleCnt < IdleHighCycles);
  // counter wraps once per period, pulse on the last count
  assign linkPulse = &linkCnt;

  always_ff @(posedge clkTx)
  begin
    if (rst)
    begin
      // no tp_idl after reset
      idleCnt <= IdleHighCycles;
      linkCnt <= '0;
    end
    else if (slot.active)
    begin
      idleCnt <= '0;
      linkCnt <= '0;
    end
    else
    begin
      if (tpIdle)
      begin
        idleCnt <= idleCnt + 1'b1;
      end
      linkCnt <= linkCnt + 1'b1;
    end
  end

  //////////////////////////////
  // output drivers
  //////////////////////////////

  always_ff @(posedge clkTx)
  begin
    if (rst)
    begin
      tdP <= 1'b0;
      tdM <= 1'b0;
    end
    else if (slot.active)
    begin
      tdP <= manchester;
      tdM <= ~manchester;
    end
    else if (tpIdle || linkPulse)
    begin
      // tp_idl and link pulses are both positive on the pair
      tdP <= 1'b1;
      tdM <= 1'b0;
    end
    else
    begin
      // both low, line released
      tdP <= 1'b0;
      tdM <= 1'b0;
    end
  end

endmodule

// File: hw/ethTxTop.sv
`timescale 1ns/100ps

module ethTxTop import ethTxPkg::*; (
  input  logic   clkTx,
  input  logic   rst,
  // wishbone classic slave
  input  logic   wbCyc,
  input  logic   wbStb,
  input  logic   wbWe,
  input  wbAddrT wbAdr,
  input  byteT   wbDatW,
  output byteT   wbDatR,
  output logic   wbAck,
  // twisted pair
  output logic   tdP,
  output logic   tdM
);

  // buffer write side
  logic     bufWrEn;
  bufAddrT  bufWrAddr;
  byteT     bufWrData;
  // buffer read side
  bufAddrT  bufRdAddr;
  byteT     bufRdData;
  // control
  txCmdT    txCmd;
  logic     busy;
  lineSlotT slot;

  busDecode i_busDecode (
    .clkTx     (clkTx),
    .rst       (rst),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatW    (wbDatW),
    .busy      (busy),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .bufWrEn   (bufWrEn),
    .bufWrAddr (bufWrAddr),
    .bufWrData (bufWrData),
    .txCmd     (txCmd)
  );

  frameRam i_frameRam (
    .clkTx     (clkTx),
    .bufWrEn   (bufWrEn),
    .bufWrAddr (bufWrAddr),
    .bufWrData (bufWrData),
    .bufRdAddr (bufRdAddr),
    .bufRdData (bufRdData)
  );

  frameSequencer i_frameSequencer (
    .clkTx     (clkTx),
    .rst       (rst),
    .txCmd     (txCmd),
    .bufRdData (bufRdData),
    .busy      (busy),
    .bufRdAddr (bufRdAddr),
    .slot      (slot)
  );

  lineEncoder i_lineEncoder (
    .clkTx (clkTx),
    .rst   (rst),
    .slot  (slot),
    .tdP   (tdP),
    .tdM   (tdM)
  );

endmodule

// File: testbench/ethTxModel.svh
`ifndef ETH_TX_MODEL_SVH
`define ETH_TX_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// ethernet crc-32, reflected form
// 0xEDB88320 is the bit reversal of the 0x04C11DB7 generator
function automatic crcT ethCrc(input byteT data[$]);
  crcT c;
  int  i;
  int  b;
  c = 32'hFFFFFFFF;
  for (i = 0; i < data.size(); i++)
  begin
    c = c ^ {24'h0, data[i]};
    for (b = 0; b < 8; b++)
    begin
      if (c[0])
        c = (c >> 1) ^ 32'hEDB88320;
      else
        c = c >> 1;
    end
  end
  // final complement gives the fcs value
  return ~c;
endfunction

// bytes as they should appear on the line, in order
// preamble, sfd, payload, then fcs low byte first
task automatic expectedFrame(input byteT data[$], output byteT frame[$]);
  crcT fcs;
  int  i;
  frame = {};
  for (i = 0; i < 7; i++)
  begin
    frame.push_back(8'h55);
  end
  frame.push_back(8'hD5);
  for (i = 0; i < data.size(); i++)
  begin
    frame.push_back(data[i]);
  end
  fcs = ethCrc(data);
  for (i = 0; i < 4; i++)
  begin
    frame.push_back(fcs[8*i +: 8]);
  end
endtask

`endif

// File: testbench/tbEthTx.sv
`timescale 1ns/100ps

module tbEthTx import ethTxPkg::*; ();

  `include "ethTxModel.svh"

  // longest frame in clocks, three frames plus three link periods
  localparam longint WatchdogNs = 3 * 16 * (8 + 512 + 4) * 4 + 3 * longint'(LinkPulsePeriod) * 4;

  logic   clkTx;
  logic   rst;
  logic   wbCyc;
  logic   wbStb;
  logic   wbWe;
  wbAddrT wbAdr;
  byteT   wbDatW;
  byteT   wbDatR;
  logic   wbAck;
  logic   tdP;
  logic   tdM;

  integer seed = 32'h977e;
  string  curTest;
  int     testErrors;
  int     passCount;
  int     failCount;
  byteT   gotBytes[$];

  ethTxTop i_ethTxTop (
    .clkTx  (clkTx),
    .rst    (rst),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck),
    .tdP    (tdP),
    .tdM    (tdM)
  );

  always #2 clkTx = ~clkTx;

  // every ack is a single-cycle pulse
  assert property (@(posedge clkTx) disable iff (rst) wbAck |=> !wbAck)
  else
  begin
    $display("%s: ack stayed high for more than one cycle", curTest);
    testErrors++;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // four-state compare, an unknown value never matches
  task automatic checkValue(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("** Error %s: %s expected %0h, actual %0h", curTest, what, exp, act);
      testErrors++;
    end
  endtask

  task automatic finishTest();
    if (testErrors == 0)
    begin
      passCount++;
      $display("test %s: passed", curTest);
    end
    else
    begin
      failCount++;
      $display("test %s: failed with %0d errors", curTest, testErrors);
    end
    testErrors = 0;
  endtask

  // classic cycle, ack sampled on the rising edge
  task automatic wbWrite(input wbAddrT addr, input byteT data);
    @(posedge clkTx);
    #1;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = addr;
    wbDatW = data;
    do @(posedge clkTx); while (!wbAck);
    #1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbRead(input wbAddrT addr, output byteT data);
    @(posedge clkTx);
    #1;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = addr;
    do @(posedge clkTx); while (!wbAck);
    data = wbDatR;
    #1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  // decode one frame from the pair, then check tp_idl
  task automatic captureFrame(input int nBytes);
    logic h1;
    logic h2;
    byteT cur;
    int   i;
    gotBytes = {};
    // tdM only goes high inside an active half-bit
    do @(negedge clkTx); while (!tdM);
    for (i = 0; i < nBytes * 8; i++)
    begin
      if (i > 0)
        @(negedge clkTx);
      h1 = tdP;
      assert (tdM == ~tdP)
      else
      begin
        $display("%s: tdM is not the complement of tdP in bit %0d", curTest, i);
        testErrors++;
      end
      @(negedge clkTx);
      h2 = tdP;
      assert (tdM == ~tdP && h1 != h2)
      else
      begin
        $display("%s: no manchester transition in bit %0d", curTest, i);
        testErrors++;
      end
      // second half carries the bit value
      cur = {h2, cur[7:1]};
      if (i % 8 == 7)
        gotBytes.push_back(cur);
    end
    repeat (IdleHighCycles)
    begin
      @(negedge clkTx);
      assert (tdP && !tdM)
      else
      begin
        $display("%s: line not held high during end-of-frame idle", curTest);
        testErrors++;
      end
    end
    @(negedge clkTx);
    assert (!tdP && !tdM)
    else
    begin
      $display("%s: line not released after end-of-frame idle", curTest);
      testErrors++;
    end
  endtask

  task automatic runFrame(input string name, input bit interfere);
    byteT payload[$];
    byteT expFrame[$];
    byteT rd;
    int   len;
    int   i;
    curTest = name;
    len = ($unsigned($random(seed)) % 512) + 1;
    for (i = 0; i < len; i++)
    begin
      payload.push_back($random(seed));
      wbWrite(i, payload[i]);
    end
    wbWrite(RegLength, len[7:0]);
    wbWrite(RegLengthHi, len >> 8);
    expectedFrame(payload, expFrame);
    fork
      captureFrame(expFrame.size());
      begin
        wbWrite(RegControl, 8'h01);
        if (interfere)
        begin
          wbRead(RegControl, rd);
          checkValue("busy during frame", 1, rd);
          // both must be dropped while busy
          wbWrite(0, ~payload[0]);
          wbWrite(RegControl, 8'h01);
        end
      end
    join
    // frame length is covered by the idle check right after the last bit
    for (i = 0; i < expFrame.size() && i < gotBytes.size(); i++)
    begin
      checkValue($sformatf("byte %0d", i), expFrame[i], gotBytes[i]);
    end
    wbRead(RegControl, rd);
    checkValue("busy after frame", 0, rd);
    if (interfere)
    begin
      repeat (300)
      begin
        @(negedge clkTx);
        assert (!tdM)
        else
        begin
          $display("%s: a second frame started after an ignored start", curTest);
          testErrors++;
        end
      end
    end
    finishTest();
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    int   cnt;
    byteT rd;
    clkTx  = 1'b0;
    rst    = 1'b1;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    testErrors = 0;
    passCount  = 0;
    failCount  = 0;
    curTest    = "reset";
    repeat (16) @(posedge clkTx);
    #1;
    rst = 1'b0;

    @(negedge clkTx);
    checkValue("tdP after reset", 0, tdP);
    checkValue("tdM after reset", 0, tdM);
    wbRead(RegControl, rd);
    checkValue("status after reset", 0, rd);
    finishTest();

    runFrame("frame1", 1'b0);
    runFrame("frame2Busy", 1'b1);
    runFrame("frame3", 1'b0);

    // two consecutive pulses give the spacing
    curTest = "linkPulse";
    do @(negedge clkTx); while (!tdP);
    checkValue("pulse tdM", 0, tdM);
    @(negedge clkTx);
    checkValue("pulse width", 0, tdP);
    cnt = 1;
    do
    begin
      @(negedge clkTx);
      cnt++;
    end
    while (!tdP);
    checkValue("pulse tdM", 0, tdM);
    checkValue("pulse spacing", LinkPulsePeriod, cnt);
    finishTest();

    $display("tests passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(WatchdogNs);
    $display("timeout: the run did not finish in %0d ns", WatchdogNs);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: ethTx.f
+incdir+testbench
common/ethTxPkg.sv
hw/busDecode.sv
hw/frameRam.sv
txFrame/crc32Serial.sv
txFrame/frameSequencer.sv
lineCoder/lineEncoder.sv
hw/ethTxTop.sv
testbench/tbEthTx.sv
